//--- design/codec_types_pkg.sv
// Pixel codec types

package codec_types_pkg;

    // RGB888 input pixel, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // Top bit is always zero
    typedef struct packed {
        logic       pad;
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb555_t;

    // One output word, read as either layout
    typedef union packed {
        rgb565_t rgb565;
        rgb555_t rgb555;
    } pixel16_u;

    typedef enum logic {
        FMT_RGB565 = 1'b0,
        FMT_RGB555 = 1'b1
    } pix_fmt_e;

    // Conversions in flight between decode and converter
    localparam int CONV_CREDITS = 1;
    localparam int CREDIT_W = $clog2(CONV_CREDITS + 1);

    // Converter FSM, one-hot
    localparam logic [2:0] ST_IDLE    = 3'b001;
    localparam logic [2:0] ST_PROCESS = 3'b010;
    localparam logic [2:0] ST_OUTPUT  = 3'b100;

endpackage

//--- design/axi_regmap_pkg.sv
// AXI4-Lite register map

package axi_regmap_pkg;

    // Register offsets
    localparam logic [7:0] REG_PIXEL_LO  = 8'h00;
    localparam logic [7:0] REG_PIXEL_HI  = 8'h04;
    localparam logic [7:0] REG_CONTROL   = 8'h08;
    localparam logic [7:0] REG_STATUS    = 8'h0C;
    localparam logic [7:0] REG_PIXEL_OUT = 8'h10;

    // Control bits
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_FMT_BIT   = 1;

    // Status bits
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- design/codec_if.sv
// Decode to converter link

interface codec_if;

    // Request, sent only while the decode holds a credit
    logic                      req_valid;
    codec_types_pkg::rgb888_t  req_pixel;
    codec_types_pkg::pix_fmt_e req_fmt;

    // Credit return, result valid in the same cycle
    logic                      credit;
    codec_types_pkg::pixel16_u result;

    modport decode (
        output req_valid,
        output req_pixel,
        output req_fmt,
        input  credit,
        input  result
    );

    modport convert (
        input  req_valid,
        input  req_pixel,
        input  req_fmt,
        output credit,
        output result
    );

endinterface

//--- design/axi_reg_decode.sv
// AXI4-Lite register decode for the pixel codec

module axi_reg_decode (
    input  logic        s_axi_aclk,
    input  logic        s_axi_aresetn,

    input  logic [7:0]  s_axi_awaddr,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,

    input  logic [31:0] s_axi_wdata,
    input  logic [3:0]  s_axi_wstrb,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,

    output logic [1:0]  s_axi_bresp,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,

    input  logic [7:0]  s_axi_araddr,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,

    output logic [31:0] s_axi_rdata,
    output logic [1:0]  s_axi_rresp,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready,

    codec_if.decode     conv
);

    codec_types_pkg::rgb888_t                pixel_q;
    codec_types_pkg::pix_fmt_e               fmt_q;
    codec_types_pkg::pixel16_u               result_q;
    logic                                    start_pending;
    logic                                    done_q;
    logic                                    req_valid_q;
    logic [codec_types_pkg::CREDIT_W-1:0]    credits;
    logic                                    busy;
    logic                                    issue;
    logic                                    wr_accept;
    logic                                    start_wr;
    logic                                    rd_accept;
    logic [31:0]                             rd_word;

    function automatic logic addr_mapped(input logic [7:0] addr);
        case (addr)
            axi_regmap_pkg::REG_PIXEL_LO,
            axi_regmap_pkg::REG_PIXEL_HI,
            axi_regmap_pkg::REG_CONTROL,
            axi_regmap_pkg::REG_STATUS,
            axi_regmap_pkg::REG_PIXEL_OUT: addr_mapped = 1'b1;
            default:                       addr_mapped = 1'b0;
        endcase
    endfunction

    // Address and data are taken together, one write at a time
    assign wr_accept = s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
    assign start_wr  = wr_accept && (s_axi_awaddr == axi_regmap_pkg::REG_CONTROL) &&
                       s_axi_wstrb[0] && s_axi_wdata[axi_regmap_pkg::CTRL_START_BIT];
    assign rd_accept = s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;

    assign issue = start_pending && (credits != '0);
    assign busy  = start_pending ||
                   (credits != codec_types_pkg::CREDIT_W'(codec_types_pkg::CONV_CREDITS));

    assign conv.req_valid = req_valid_q;
    assign conv.req_pixel = pixel_q;
    assign conv.req_fmt   = fmt_q;

    // Write channel and register file
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_bresp   <= axi_regmap_pkg::RESP_OKAY;
            pixel_q       <= '0;
            fmt_q         <= codec_types_pkg::FMT_RGB565;
        end else begin
            s_axi_awready <= wr_accept;
            s_axi_wready  <= wr_accept;
            if (wr_accept) begin
                s_axi_bresp <= addr_mapped(s_axi_awaddr) ? axi_regmap_pkg::RESP_OKAY
                                                         : axi_regmap_pkg::RESP_SLVERR;
                case (s_axi_awaddr)
                    axi_regmap_pkg::REG_PIXEL_LO: begin
                        if (s_axi_wstrb[0]) pixel_q.blue  <= s_axi_wdata[7:0];
                        if (s_axi_wstrb[1]) pixel_q.green <= s_axi_wdata[15:8];
                    end
                    axi_regmap_pkg::REG_PIXEL_HI: begin
                        if (s_axi_wstrb[0]) pixel_q.red <= s_axi_wdata[7:0];
                    end
                    axi_regmap_pkg::REG_CONTROL: begin
                        if (s_axi_wstrb[0]) begin
                            fmt_q <= codec_types_pkg::pix_fmt_e'(
                                s_axi_wdata[axi_regmap_pkg::CTRL_FMT_BIT]);
                        end
                    end
                    default: ;
                endcase
            end
            if (s_axi_awready) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    // Request issue, credit count and result capture
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            req_valid_q   <= 1'b0;
            start_pending <= 1'b0;
            credits       <= codec_types_pkg::CREDIT_W'(codec_types_pkg::CONV_CREDITS);
            done_q        <= 1'b0;
            result_q      <= '0;
        end else begin
            req_valid_q <= issue;
            if (conv.credit) begin
                result_q <= conv.result;
                // A queued start will produce a newer result
                done_q   <= !start_pending;
            end
            if (issue) begin
                start_pending <= 1'b0;
            end
            case ({conv.credit, issue})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            // New start wins over the issue on the same edge
            if (start_wr) begin
                start_pending <= 1'b1;
                done_q        <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (s_axi_araddr)
            axi_regmap_pkg::REG_PIXEL_LO:  rd_word[15:0] = pixel_q[15:0];
            axi_regmap_pkg::REG_PIXEL_HI:  rd_word[7:0]  = pixel_q.red;
            axi_regmap_pkg::REG_CONTROL: begin
                rd_word[axi_regmap_pkg::CTRL_START_BIT] = start_pending;
                rd_word[axi_regmap_pkg::CTRL_FMT_BIT]   = fmt_q;
            end
            axi_regmap_pkg::REG_STATUS: begin
                rd_word[axi_regmap_pkg::STAT_BUSY_BIT] = busy;
                rd_word[axi_regmap_pkg::STAT_DONE_BIT] = done_q;
            end
            axi_regmap_pkg::REG_PIXEL_OUT: rd_word[15:0] = result_q;
            default:                       rd_word = '0;
        endcase
    end

    // Read channel, data held until rready
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            s_axi_rdata   <= '0;
            s_axi_rresp   <= axi_regmap_pkg::RESP_OKAY;
        end else begin
            s_axi_arready <= rd_accept;
            if (rd_accept) begin
                s_axi_rdata <= rd_word;
                s_axi_rresp <= addr_mapped(s_axi_araddr) ? axi_regmap_pkg::RESP_OKAY
                                                         : axi_regmap_pkg::RESP_SLVERR;
            end
            if (s_axi_arready) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

endmodule

//--- design/pixel_convert.sv
// RGB888 to 16-bit pixel converter

module pixel_convert (
    input  logic     s_axi_aclk,
    input  logic     s_axi_aresetn,
    codec_if.convert conv
);

    logic [2:0]                state_q;
    logic [2:0]                state_d;
    codec_types_pkg::rgb888_t  pix_q;
    codec_types_pkg::pix_fmt_e fmt_q;
    codec_types_pkg::pixel16_u result_q;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state_q <= codec_types_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // No refusal path, the credit means we are idle
    always_comb begin
        case (state_q)
            codec_types_pkg::ST_IDLE:
                state_d = conv.req_valid ? codec_types_pkg::ST_PROCESS
                                         : codec_types_pkg::ST_IDLE;
            codec_types_pkg::ST_PROCESS: state_d = codec_types_pkg::ST_OUTPUT;
            codec_types_pkg::ST_OUTPUT:  state_d = codec_types_pkg::ST_IDLE;
            default:                     state_d = codec_types_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge s_axi_aclk) begin
        // Request fields only live for one cycle
        if (state_q == codec_types_pkg::ST_IDLE && conv.req_valid) begin
            pix_q <= conv.req_pixel;
            fmt_q <= conv.req_fmt;
        end
        // Truncate to the top bits of each channel
        if (state_q == codec_types_pkg::ST_PROCESS) begin
            case (fmt_q)
                codec_types_pkg::FMT_RGB555: begin
                    result_q.rgb555 <= '{pad:   1'b0,
                                         red:   pix_q.red[7:3],
                                         green: pix_q.green[7:3],
                                         blue:  pix_q.blue[7:3]};
                end
                default: begin
                    result_q.rgb565 <= '{red:   pix_q.red[7:3],
                                         green: pix_q.green[7:2],
                                         blue:  pix_q.blue[7:3]};
                end
            endcase
        end
    end

    assign conv.result = result_q;
    assign conv.credit = (state_q == codec_types_pkg::ST_OUTPUT);

endmodule

//--- design/display_codec_top.sv
// Display pixel codec, AXI4-Lite top level

module display_codec_top (
    input  logic        s_axi_aclk,
    input  logic        s_axi_aresetn,

    input  logic [7:0]  s_axi_awaddr,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,

    input  logic [31:0] s_axi_wdata,
    input  logic [3:0]  s_axi_wstrb,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,

    output logic [1:0]  s_axi_bresp,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,

    input  logic [7:0]  s_axi_araddr,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,

    output logic [31:0] s_axi_rdata,
    output logic [1:0]  s_axi_rresp,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready
);

    codec_if conv_link ();

    axi_reg_decode u_decode (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .conv          (conv_link.decode)
    );

    pixel_convert u_convert (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .conv          (conv_link.convert)
    );

endmodule

//--- tests/display_codec_tb.sv
// Display codec testbench

module display_codec_tb;

    logic        s_axi_aclk;
    logic        s_axi_aresetn;
    logic [7:0]  s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [7:0]  s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;

    // Stimulus table with one entry per conversion
    string       row_name[$];
    logic [23:0] row_pixel[$];
    logic        row_fmt[$];
    int          row_bp[$];
    logic [31:0] row_expect[$];

    logic [23:0] lfsr_state;
    int          value_errors;
    int          protocol_errors;
    int          cycle_limit = 0;
    int          cycles;

    display_codec_top u_display_codec_top (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #20 s_axi_aclk = ~s_axi_aclk;
    end

    initial begin
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge s_axi_aclk);
            cycles++;
        end
        $display("Timed out after %0d cycles before the tests finished", cycles);
        $display("Value errors %0d, protocol errors %0d", value_errors, protocol_errors);
        $display("Result: FAILED");
        $finish;
    end

    // Fibonacci LFSR with taps 24 23 22 17
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[23] ^ lfsr_state[22] ^ lfsr_state[21] ^ lfsr_state[16];
        lfsr_state = {lfsr_state[22:0], fb};
        return fb;
    endfunction

    function automatic logic [23:0] lfsr_bits(input int n);
        logic [23:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[22:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Keep the top bits of each channel
    function automatic logic [31:0] packed_word(input logic [23:0] pix, input logic fmt);
        if (fmt) begin
            return {16'h0, 1'b0, pix[23:19], pix[15:11], pix[7:3]};
        end else begin
            return {16'h0, pix[23:19], pix[15:10], pix[7:3]};
        end
    endfunction

    task automatic add_row(input string name, input logic [23:0] pix, input logic fmt,
                           input int bp, input logic [31:0] expected);
        row_name.push_back(name);
        row_pixel.push_back(pix);
        row_fmt.push_back(fmt);
        row_bp.push_back(bp);
        row_expect.push_back(expected);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        value_errors++;
        $display("Fail %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic report_protocol(input string what);
        protocol_errors++;
        $display("Error: %s", what);
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int bp, output logic [1:0] resp);
        @(posedge s_axi_aclk);
        s_axi_awaddr  <= addr;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= strb;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        do begin
            @(posedge s_axi_aclk);
        end while (!s_axi_awready);
        if (!s_axi_wready) begin
            report_protocol("wready did not rise together with awready");
        end
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        do begin
            @(posedge s_axi_aclk);
        end while (!s_axi_bvalid);
        resp = s_axi_bresp;
        // Response must hold while bready is low
        for (int k = 0; k < bp; k++) begin
            @(posedge s_axi_aclk);
            if (!s_axi_bvalid || s_axi_bresp !== resp) begin
                report_protocol("write response dropped or changed while bready was low");
            end
        end
        s_axi_bready <= 1'b1;
        @(posedge s_axi_aclk);
        s_axi_bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, input int bp,
                            output logic [31:0] data, output logic [1:0] resp);
        @(posedge s_axi_aclk);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        do begin
            @(posedge s_axi_aclk);
        end while (!s_axi_arready);
        s_axi_arvalid <= 1'b0;
        do begin
            @(posedge s_axi_aclk);
        end while (!s_axi_rvalid);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        for (int k = 0; k < bp; k++) begin
            @(posedge s_axi_aclk);
            if (!s_axi_rvalid || s_axi_rdata !== data || s_axi_rresp !== resp) begin
                report_protocol("read data dropped or changed while rready was low");
            end
        end
        s_axi_rready <= 1'b1;
        @(posedge s_axi_aclk);
        s_axi_rready <= 1'b0;
    endtask

    task automatic check_write(input string name, input logic [7:0] addr,
                               input logic [31:0] data, input logic [3:0] strb,
                               input int bp, input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(addr, data, strb, bp, resp);
        if (resp !== exp_resp) begin
            report_mismatch({name, " bresp"}, {30'h0, exp_resp}, {30'h0, resp});
        end
    endtask

    task automatic check_read(input string name, input logic [7:0] addr, input int bp,
                              input logic [31:0] exp_data, input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, bp, data, resp);
        if (data !== exp_data) begin
            report_mismatch(name, exp_data, data);
        end
        if (resp !== exp_resp) begin
            report_mismatch({name, " rresp"}, {30'h0, exp_resp}, {30'h0, resp});
        end
    endtask

    task automatic poll_done(input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        int          polls;
        data  = '0;
        polls = 0;
        while (!data[axi_regmap_pkg::STAT_DONE_BIT] && polls < 20) begin
            axi_read(axi_regmap_pkg::REG_STATUS, 0, data, resp);
            polls++;
        end
        if (!data[axi_regmap_pkg::STAT_DONE_BIT]) begin
            report_protocol({"done never set for ", name});
        end
    endtask

    // Two starts with bready held high so the second lands while the credit is out
    task automatic double_start(input logic fmt_a, input logic fmt_b);
        logic [31:0] ctrl;
        ctrl = '0;
        ctrl[axi_regmap_pkg::CTRL_START_BIT] = 1'b1;
        ctrl[axi_regmap_pkg::CTRL_FMT_BIT]   = fmt_a;
        @(posedge s_axi_aclk);
        s_axi_awaddr  <= axi_regmap_pkg::REG_CONTROL;
        s_axi_wdata   <= ctrl;
        s_axi_wstrb   <= 4'b0001;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        s_axi_bready  <= 1'b1;
        do begin
            @(posedge s_axi_aclk);
        end while (!s_axi_awready);
        ctrl[axi_regmap_pkg::CTRL_FMT_BIT] = fmt_b;
        s_axi_wdata <= ctrl;
        do begin
            @(posedge s_axi_aclk);
        end while (!s_axi_awready);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        do begin
            @(posedge s_axi_aclk);
        end while (!s_axi_bvalid);
        s_axi_bready <= 1'b0;
        if (s_axi_bresp !== axi_regmap_pkg::RESP_OKAY) begin
            report_mismatch("double start bresp", 32'h0, {30'h0, s_axi_bresp});
        end
    endtask

    initial begin
        logic [23:0] pix;
        logic [23:0] bits;
        logic        fmt;
        logic [31:0] ctrl;
        logic [31:0] stat;
        int          bp;

        s_axi_aresetn <= 1'b0;
        s_axi_awaddr  <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wstrb   <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b0;
        s_axi_araddr  <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        lfsr_state      = 24'd98594;

        add_row("black", 24'h000000, 1'b0, 0, 32'h0000_0000);
        add_row("white_555", 24'hFFFFFF, 1'b1, 1, 32'h0000_7FFF);
        add_row("red", 24'hFF0000, 1'b0, 2, 32'h0000_F800);
        add_row("green_555", 24'h00FF00, 1'b1, 3, 32'h0000_03E0);
        add_row("blue", 24'h0000FF, 1'b0, 1, 32'h0000_001F);
        add_row("mixed", 24'h12AB7C, 1'b0, 0, 32'h0000_154F);
        add_row("mixed_555", 24'h12AB7C, 1'b1, 2, 32'h0000_0AAF);
        for (int i = 0; i < 5; i++) begin
            pix  = lfsr_bits(24);
            bits = lfsr_bits(1);
            fmt  = bits[0];
            bits = lfsr_bits(2);
            bp   = int'(bits[1:0]);
            add_row($sformatf("lfsr_%0d", i), pix, fmt, bp, packed_word(pix, fmt));
        end
        cycle_limit = row_name.size() * 60 + 400;

        repeat (16) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b1;

        check_read("reset status", axi_regmap_pkg::REG_STATUS, 0, 32'h0, 2'b00);
        check_read("reset out", axi_regmap_pkg::REG_PIXEL_OUT, 0, 32'h0, 2'b00);
        check_read("reset control", axi_regmap_pkg::REG_CONTROL, 0, 32'h0, 2'b00);

        // Byte strobes on the pixel registers
        check_write("lo full", axi_regmap_pkg::REG_PIXEL_LO, 32'hDEAD_BEEF, 4'hF, 1, 2'b00);
        check_read("lo full", axi_regmap_pkg::REG_PIXEL_LO, 1, 32'h0000_BEEF, 2'b00);
        check_write("hi full", axi_regmap_pkg::REG_PIXEL_HI, 32'hFFFF_FF5A, 4'hF, 0, 2'b00);
        check_read("hi full", axi_regmap_pkg::REG_PIXEL_HI, 2, 32'h0000_005A, 2'b00);
        check_write("lo byte1", axi_regmap_pkg::REG_PIXEL_LO, 32'h1234_5678, 4'b0010, 0, 2'b00);
        check_read("lo byte1", axi_regmap_pkg::REG_PIXEL_LO, 0, 32'h0000_56EF, 2'b00);
        check_write("hi no b0", axi_regmap_pkg::REG_PIXEL_HI, 32'h0000_0099, 4'b1110, 0, 2'b00);
        check_read("hi no b0", axi_regmap_pkg::REG_PIXEL_HI, 0, 32'h0000_005A, 2'b00);

        check_write("unmapped 14", 8'h14, 32'hFFFF_FFFF, 4'hF, 2, 2'b10);
        check_write("unmapped 3c", 8'h3C, 32'hFFFF_FFFF, 4'hF, 0, 2'b10);
        check_read("unmapped 14", 8'h14, 1, 32'h0, 2'b10);
        check_read("unmapped 3c", 8'h3C, 3, 32'h0, 2'b10);
        check_read("kept lo", axi_regmap_pkg::REG_PIXEL_LO, 0, 32'h0000_56EF, 2'b00);
        check_read("kept hi", axi_regmap_pkg::REG_PIXEL_HI, 0, 32'h0000_005A, 2'b00);
        check_read("kept control", axi_regmap_pkg::REG_CONTROL, 0, 32'h0, 2'b00);

        stat = '0;
        stat[axi_regmap_pkg::STAT_DONE_BIT] = 1'b1;
        for (int i = 0; i < row_name.size(); i++) begin
            bp = row_bp[i];
            check_write({row_name[i], " lo"}, axi_regmap_pkg::REG_PIXEL_LO,
                        {16'h0, row_pixel[i][15:0]}, 4'b0011, bp, 2'b00);
            check_write({row_name[i], " hi"}, axi_regmap_pkg::REG_PIXEL_HI,
                        {24'h0, row_pixel[i][23:16]}, 4'b0001, bp, 2'b00);
            ctrl = '0;
            ctrl[axi_regmap_pkg::CTRL_START_BIT] = 1'b1;
            ctrl[axi_regmap_pkg::CTRL_FMT_BIT]   = row_fmt[i];
            check_write({row_name[i], " start"}, axi_regmap_pkg::REG_CONTROL,
                        ctrl, 4'b0001, bp, 2'b00);
            poll_done(row_name[i]);
            check_read({row_name[i], " out"}, axi_regmap_pkg::REG_PIXEL_OUT, bp,
                       row_expect[i], 2'b00);
            check_read({row_name[i], " status"}, axi_regmap_pkg::REG_STATUS, bp, stat, 2'b00);
            // Start clears itself and the format stays
            ctrl[axi_regmap_pkg::CTRL_START_BIT] = 1'b0;
            check_read({row_name[i], " control"}, axi_regmap_pkg::REG_CONTROL, bp,
                       ctrl, 2'b00);
        end

        check_write("pair lo", axi_regmap_pkg::REG_PIXEL_LO, 32'h0000_AB7C, 4'b0011, 0, 2'b00);
        check_write("pair hi", axi_regmap_pkg::REG_PIXEL_HI, 32'h0000_0012, 4'b0001, 0, 2'b00);
        double_start(1'b0, 1'b1);
        poll_done("pair");
        check_read("pair out", axi_regmap_pkg::REG_PIXEL_OUT, 1, 32'h0000_0AAF, 2'b00);
        check_read("pair status", axi_regmap_pkg::REG_STATUS, 0, stat, 2'b00);
        check_read("pair control", axi_regmap_pkg::REG_CONTROL, 0, 32'h0000_0002, 2'b00);

        $display("Value errors %0d, protocol errors %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- display_codec.f
design/codec_types_pkg.sv
design/axi_regmap_pkg.sv
design/codec_if.sv
design/axi_reg_decode.sv
design/pixel_convert.sv
design/display_codec_top.sv
tests/display_codec_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the display codec testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --top-module display_codec_tb -f display_codec.f \
    -o display_codec_sim > build.log 2>&1 &&
./obj_dir/display_codec_sim > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1
